// File: Makefile
# Verilator flow for the AHB-Lite memory subsystem

VERILATOR ?= verilator
VFLAGS    ?= --timing
TOP       := ahb_mem_tb
FILELIST  := sources.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := TEST RESULT: PASS

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# Pass or fail comes from the log, not the exit status of the run
sim: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Pass line missing in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: sources.f
verilog/ahb_sys_pkg.sv
verilog/ahb_pma_check.sv
verilog/ahb_addr_stage.sv
verilog/ahb_dp_ram.sv
verilog/ahb_mmio_catch.sv
verilog/ahb_mem_top.sv
tb/ahb_mem_tb.sv

// File: tb/ahb_mem_tb.sv
/*
 * Testbench for the dual-port AHB-Lite memory subsystem: clock, reset,
 * PMA setup, vector table, shadow memory, pipelined random traffic
 */
module ahb_mem_tb import ahb_sys_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int              PMA_CNT   = 4;
  localparam int              MEM_WORDS = 2048;
  localparam int              AW        = $clog2(MEM_WORDS);
  localparam logic [PLEN-1:0] TOHOST    = 32'h8000_1000;
  localparam logic [PLEN-1:0] UART_TX   = 32'h8000_1080;
  localparam int              TIMEOUT   = 20;
  localparam int              RAND_OPS  = 400;
  localparam int              SEED      = 48362;

  // Table field codes
  localparam bit DP      = 1'b0;
  localparam bit IP      = 1'b1;
  localparam bit RD      = 1'b0;
  localparam bit WR      = 1'b1;
  localparam bit RSP_OK  = 1'b0;
  localparam bit RSP_ERR = 1'b1;

  typedef struct packed {
    logic            port;
    logic [PLEN-1:0] addr;
    hsize_t          size;
    logic            write;
    logic [XLEN-1:0] data;
    logic            err;
  } vec_t;

  ////////////////////////////////////////////////////////////////////////////
  // Directed vectors, write data is lane aligned as on HWDATA
  ////////////////////////////////////////////////////////////////////////////

  localparam int NV = 28;
  localparam vec_t VECTORS [NV] = '{
    '{DP, 32'h8000_0000, HSIZE_WORD, WR, 32'h0000_0001, RSP_OK},
    '{DP, 32'h8000_0100, HSIZE_WORD, WR, 32'h1122_3344, RSP_OK},
    '{DP, 32'h8000_0102, HSIZE_HALF, WR, 32'hBEEF_0000, RSP_OK},
    '{DP, 32'h8000_0101, HSIZE_BYTE, WR, 32'h0000_5A00, RSP_OK},
    '{DP, 32'h8000_0100, HSIZE_WORD, RD, 32'h0000_0000, RSP_OK},
    '{DP, 32'h8000_0102, HSIZE_HALF, RD, 32'h0000_0000, RSP_OK},
    '{DP, 32'h8000_0101, HSIZE_BYTE, RD, 32'h0000_0000, RSP_OK},
    '{DP, 32'h8000_0107, HSIZE_BYTE, WR, 32'hC300_0000, RSP_OK},
    '{DP, 32'h8000_0104, HSIZE_HALF, WR, 32'h0000_7E81, RSP_OK},
    '{DP, 32'h8000_0107, HSIZE_BYTE, RD, 32'h0000_0000, RSP_OK},
    '{DP, 32'h8000_0104, HSIZE_HALF, RD, 32'h0000_0000, RSP_OK},
    // Fetch sees data-port writes
    '{DP, 32'h8000_0040, HSIZE_WORD, WR, 32'h0013_0513, RSP_OK},
    '{IP, 32'h8000_0040, HSIZE_WORD, RD, 32'h0000_0000, RSP_OK},
    '{IP, 32'h8000_0100, HSIZE_WORD, RD, 32'h0000_0000, RSP_OK},
    // Read-only table and unmapped space
    '{DP, 32'h8000_1100, HSIZE_WORD, WR, 32'hDEAD_BEEF, RSP_ERR},
    '{DP, 32'h8000_1100, HSIZE_WORD, RD, 32'h0000_0000, RSP_OK},
    '{IP, 32'h8000_1100, HSIZE_WORD, RD, 32'h0000_0000, RSP_ERR},
    '{DP, 32'h9000_0000, HSIZE_WORD, WR, 32'h0BAD_0BAD, RSP_ERR},
    '{DP, 32'h9000_0000, HSIZE_WORD, RD, 32'h0000_0000, RSP_ERR},
    '{IP, 32'h9000_0000, HSIZE_WORD, RD, 32'h0000_0000, RSP_ERR},
    // Aliases 0x9000_0000 in the RAM, must be untouched
    '{DP, 32'h8000_0000, HSIZE_WORD, RD, 32'h0000_0000, RSP_OK},
    // MMIO
    '{DP, 32'h8000_1000, HSIZE_WORD, WR, 32'h0000_0539, RSP_OK},
    '{DP, 32'h8000_1000, HSIZE_WORD, RD, 32'h0000_0000, RSP_OK},
    '{DP, 32'h8000_1080, HSIZE_WORD, WR, 32'h0000_0048, RSP_OK},
    '{DP, 32'h8000_1080, HSIZE_BYTE, WR, 32'h0000_0069, RSP_OK},
    '{DP, 32'h8000_1080, HSIZE_WORD, RD, 32'h0000_0000, RSP_OK},
    '{DP, 32'h8000_1080, HSIZE_WORD, WR, 32'hFFFF_FF0A, RSP_OK},
    '{DP, 32'h8000_0100, HSIZE_BYTE, RD, 32'h0000_0000, RSP_OK}
  };

  logic                           HCLK;
  logic                           rst;
  pma_cfg_t [PMA_CNT-1:0]         pma_cfg;
  logic     [PMA_CNT-1:0][31:0]   pma_adr;
  htrans_t                        ins_htrans;
  logic     [PLEN-1:0]            ins_haddr;
  logic                           ins_hwrite;
  hsize_t                         ins_hsize;
  logic     [XLEN-1:0]            ins_hrdata;
  logic                           ins_hready;
  logic                           ins_hresp;
  htrans_t                        dat_htrans;
  logic     [PLEN-1:0]            dat_haddr;
  logic                           dat_hwrite;
  hsize_t                         dat_hsize;
  logic     [XLEN-1:0]            dat_hwdata;
  logic     [XLEN-1:0]            dat_hrdata;
  logic                           dat_hready;
  logic                           dat_hresp;
  logic                           tohost_done;
  logic     [XLEN-1:0]            tohost_code;
  logic                           uart_valid;
  logic     [7:0]                 uart_data;

  // Shadow of the RAM, same wrap as the word index
  logic [XLEN-1:0] shadow [MEM_WORDS];
  logic [7:0]      uart_expect [$];
  logic [7:0]      uart_seen [$];
  int              errors;
  int              checks;

  // Transfers in their data phase during pipelined traffic
  logic            i_pend;
  logic [XLEN-1:0] i_exp;
  logic            d_pend;
  logic            d_wr_q;
  logic [XLEN-1:0] d_wdata;
  logic [XLEN-1:0] d_exp;
  logic [XLEN-1:0] d_mask;

  ahb_mem_top #(
    .PMA_CNT   (PMA_CNT),
    .MEM_WORDS (MEM_WORDS),
    .TOHOST    (TOHOST),
    .UART_TX   (UART_TX)
  ) u_ahb_mem_top (
    .HCLK          (HCLK),
    .rst_i         (rst),
    .pma_cfg_i     (pma_cfg),
    .pma_adr_i     (pma_adr),
    .ins_htrans_i  (ins_htrans),
    .ins_haddr_i   (ins_haddr),
    .ins_hwrite_i  (ins_hwrite),
    .ins_hsize_i   (ins_hsize),
    .ins_hrdata_o  (ins_hrdata),
    .ins_hready_o  (ins_hready),
    .ins_hresp_o   (ins_hresp),
    .dat_htrans_i  (dat_htrans),
    .dat_haddr_i   (dat_haddr),
    .dat_hwrite_i  (dat_hwrite),
    .dat_hsize_i   (dat_hsize),
    .dat_hwdata_i  (dat_hwdata),
    .dat_hrdata_o  (dat_hrdata),
    .dat_hready_o  (dat_hready),
    .dat_hresp_o   (dat_hresp),
    .tohost_done_o (tohost_done),
    .tohost_code_o (tohost_code),
    .uart_valid_o  (uart_valid),
    .uart_data_o   (uart_data)
  );

  // 8 ns period
  always #4 HCLK = ~HCLK;

  // Every high cycle of the strobe is one console byte
  always @(negedge HCLK) begin
    if (rst === 1'b0 && uart_valid === 1'b1) begin
      uart_seen.push_back(uart_data);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reference model helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [AW-1:0] word_index(logic [PLEN-1:0] addr);
    return addr[AW+1:2];
  endfunction

  // Byte lanes by size and offset
  function automatic logic [3:0] lane_enables(hsize_t size, logic [1:0] offs);
    logic [3:0] lanes;
    case (size)
      HSIZE_BYTE: lanes = 4'b0001 << offs;
      HSIZE_HALF: lanes = offs[1] ? 4'b1100 : 4'b0011;
      default:    lanes = 4'b1111;
    endcase
    return lanes;
  endfunction

  function automatic logic [XLEN-1:0] lane_bits(logic [3:0] lanes);
    logic [XLEN-1:0] bits;
    for (int b = 0; b < 4; b++) begin
      bits[b*8 +: 8] = {8{lanes[b]}};
    end
    return bits;
  endfunction

  // TOHOST page is 64 bytes, UART_TX one word
  function automatic logic is_io_addr(logic [PLEN-1:0] addr);
    return (addr[PLEN-1:6] == TOHOST[PLEN-1:6]) || (addr[PLEN-1:2] == UART_TX[PLEN-1:2]);
  endfunction

  function automatic logic [XLEN-1:0] predict_read(logic [PLEN-1:0] addr);
    if (is_io_addr(addr)) begin
      return '0;
    end
    return shadow[word_index(addr)];
  endfunction

  task automatic shadow_store(input logic [PLEN-1:0] addr, input hsize_t size,
                              input logic [XLEN-1:0] data);
    logic [3:0] lanes;
    lanes = lane_enables(size, addr[1:0]);
    for (int b = 0; b < 4; b++) begin
      if (lanes[b]) begin
        shadow[word_index(addr)][b*8 +: 8] = data[b*8 +: 8];
      end
    end
  endtask

  // Byte-swapped address, so every address bit shows up
  function automatic logic [XLEN-1:0] fill_pattern(logic [PLEN-1:0] addr);
    return {addr[7:0], addr[15:8], addr[23:16], addr[31:24]} ^ 32'h0F1E_2D3C;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Checking and port access
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s got %08h expected %08h", $time, name, got, exp);
    end
  endtask

  task automatic report_timeout(input string what);
    errors++;
    $display("Timed out at %0t waiting for %s", $time, what);
  endtask

  function automatic string port_tag(logic port);
    return port ? "ins" : "dat";
  endfunction

  function automatic logic ready_of(logic port);
    return port ? ins_hready : dat_hready;
  endfunction

  function automatic logic resp_of(logic port);
    return port ? ins_hresp : dat_hresp;
  endfunction

  function automatic logic [XLEN-1:0] rdata_of(logic port);
    return port ? ins_hrdata : dat_hrdata;
  endfunction

  // Counts stalled cycles until HREADY comes back
  task automatic wait_ready(input logic port, output int waits);
    waits = 0;
    while (ready_of(port) !== 1'b1 && waits < TIMEOUT) begin
      @(negedge HCLK);
      waits++;
    end
    if (ready_of(port) !== 1'b1) begin
      report_timeout({port_tag(port), "_hready_o"});
    end
  endtask

  task automatic drive_addr(input logic port, input logic go, input logic [PLEN-1:0] addr,
                            input hsize_t size, input logic write);
    if (port == IP) begin
      ins_htrans = go ? NONSEQ : IDLE;
      ins_haddr  = addr;
      ins_hsize  = size;
      ins_hwrite = 1'b0;
    end else begin
      dat_htrans = go ? NONSEQ : IDLE;
      dat_haddr  = addr;
      dat_hsize  = size;
      dat_hwrite = write;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Single transfer from the vector table
  ////////////////////////////////////////////////////////////////////////////

  task automatic run_vector(input vec_t v);
    logic [XLEN-1:0] exp;
    logic [XLEN-1:0] bits;
    int              waits;
    bits = lane_bits(lane_enables(v.size, v.addr[1:0]));
    exp  = predict_read(v.addr);
    wait_ready(v.port, waits);
    drive_addr(v.port, 1'b1, v.addr, v.size, v.write);
    @(posedge HCLK);
    @(negedge HCLK);
    // Data phase
    drive_addr(v.port, 1'b0, v.addr, v.size, v.write);
    if (v.port == DP) begin
      dat_hwdata = v.data;
    end
    check_value({port_tag(v.port), "_hresp_o first cycle"}, 32'(resp_of(v.port)), 32'(v.err));
    wait_ready(v.port, waits);
    check_value({port_tag(v.port), "_hresp_o"}, 32'(resp_of(v.port)), 32'(v.err));
    check_value({port_tag(v.port), " wait states"}, 32'(waits), 32'(v.err));
    if (!v.err && !v.write) begin
      check_value({port_tag(v.port), "_hrdata_o"}, rdata_of(v.port) & bits, exp & bits);
    end
    if (!v.err && v.write) begin
      if (!is_io_addr(v.addr)) begin
        shadow_store(v.addr, v.size, v.data);
      end else if (v.addr[PLEN-1:2] == UART_TX[PLEN-1:2]) begin
        uart_expect.push_back(v.data[7:0]);
      end
    end
    @(posedge HCLK);
    @(negedge HCLK);
    dat_hwdata = '0;
  endtask

  task automatic wait_tohost(input logic [XLEN-1:0] code);
    int waits;
    waits = 0;
    while (tohost_done !== 1'b1 && waits < TIMEOUT) begin
      @(negedge HCLK);
      waits++;
    end
    if (tohost_done !== 1'b1) begin
      report_timeout("tohost_done_o");
    end else begin
      check_value("tohost_code_o", tohost_code, code);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Pipelined traffic on both ports
  ////////////////////////////////////////////////////////////////////////////

  // Checks the data phases in flight, then issues the next address phases
  task automatic pipe_cycle(input logic i_go, input logic [PLEN-1:0] i_addr,
                            input logic d_go, input logic d_wr, input hsize_t d_size,
                            input logic [PLEN-1:0] d_addr, input logic [XLEN-1:0] d_data);
    int waits;
    waits = 0;
    while (((i_pend && ins_hready !== 1'b1) || (d_pend && dat_hready !== 1'b1))
           && waits < TIMEOUT) begin
      @(negedge HCLK);
      waits++;
    end
    if ((i_pend && ins_hready !== 1'b1) || (d_pend && dat_hready !== 1'b1)) begin
      report_timeout("pipelined data phase");
    end
    if (i_pend) begin
      check_value("ins_hresp_o", 32'(ins_hresp), 32'h0);
      check_value("ins_hrdata_o", ins_hrdata, i_exp);
    end
    if (d_pend) begin
      check_value("dat_hresp_o", 32'(dat_hresp), 32'h0);
      if (!d_wr_q) begin
        check_value("dat_hrdata_o", dat_hrdata & d_mask, d_exp & d_mask);
      end
    end
    dat_hwdata = (d_pend && d_wr_q) ? d_wdata : '0;
    drive_addr(IP, i_go, i_addr, HSIZE_WORD, 1'b0);
    drive_addr(DP, d_go, d_addr, d_size, d_wr);
    // Predictions in issue order
    i_pend  = i_go;
    i_exp   = shadow[word_index(i_addr)];
    d_pend  = d_go;
    d_wr_q  = d_wr;
    d_wdata = d_data;
    d_mask  = lane_bits(lane_enables(d_size, d_addr[1:0]));
    d_exp   = shadow[word_index(d_addr)];
    if (d_go && d_wr) begin
      shadow_store(d_addr, d_size, d_data);
    end
    @(posedge HCLK);
    @(negedge HCLK);
  endtask

  task automatic fill_words(input logic [PLEN-1:0] base, input int count);
    logic [PLEN-1:0] addr;
    for (int w = 0; w < count; w++) begin
      addr = base + 32'(w * 4);
      pipe_cycle(1'b0, '0, 1'b1, 1'b1, HSIZE_WORD, addr, fill_pattern(addr));
    end
  endtask

  task automatic random_traffic();
    logic [31:0]     r;
    logic            i_go;
    logic [PLEN-1:0] i_addr;
    logic            d_go;
    logic            d_wr;
    hsize_t          d_size;
    logic [1:0]      offs;
    logic [PLEN-1:0] d_addr;
    for (int n = 0; n < RAND_OPS; n++) begin
      r      = $urandom();
      // Fetch window 0x300..0x3FC, never written here
      i_go   = (r[2:0] != 3'd0);
      i_addr = 32'h8000_0300 | {24'h0, r[8:3], 2'b00};
      r      = $urandom();
      d_go   = (r[2:0] != 3'd0);
      d_wr   = r[3];
      case (r[5:4])
        2'd0: begin
          d_size = HSIZE_BYTE;
          offs   = r[13:12];
        end
        2'd1: begin
          d_size = HSIZE_HALF;
          offs   = {r[12], 1'b0};
        end
        default: begin
          d_size = HSIZE_WORD;
          offs   = 2'b00;
        end
      endcase
      // Data window 0x200..0x2FF
      d_addr = 32'h8000_0200 | {24'h0, r[11:6], offs};
      pipe_cycle(i_go, i_addr, d_go, d_wr, d_size, d_addr, $urandom());
    end
    // Drain the last data phases
    pipe_cycle(1'b0, '0, 1'b0, 1'b0, HSIZE_WORD, '0, '0);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(SEED));
    errors     = 0;
    checks     = 0;
    i_pend     = 1'b0;
    d_pend     = 1'b0;
    d_wr_q     = 1'b0;
    HCLK       = 1'b0;
    rst        = 1'b1;
    ins_htrans = IDLE;
    ins_haddr  = '0;
    ins_hwrite = 1'b0;
    ins_hsize  = HSIZE_WORD;
    dat_htrans = IDLE;
    dat_haddr  = '0;
    dat_hwrite = 1'b0;
    dat_hsize  = HSIZE_WORD;
    dat_hwdata = '0;
    // RAM up to TOHOST, 64-byte TOHOST page, UART word, data table
    pma_cfg[0] = '{MAIN, 1'b1, 1'b1, 1'b1, TOR};
    pma_adr[0] = 32'h2000_0400;
    pma_cfg[1] = '{IO, 1'b1, 1'b1, 1'b0, NAPOT};
    pma_adr[1] = 32'h2000_0407;
    pma_cfg[2] = '{IO, 1'b1, 1'b1, 1'b0, NA4};
    pma_adr[2] = 32'h2000_0420;
    // Table stays writable until it is filled
    pma_cfg[3] = '{MAIN, 1'b1, 1'b1, 1'b0, TOR};
    pma_adr[3] = 32'h2000_0480;

    repeat (10) @(posedge HCLK);
    @(negedge HCLK);
    rst = 1'b0;
    @(negedge HCLK);
    check_value("ins_hready_o after reset", 32'(ins_hready), 32'h1);
    check_value("dat_hready_o after reset", 32'(dat_hready), 32'h1);
    check_value("ins_hresp_o after reset", 32'(ins_hresp), 32'h0);
    check_value("dat_hresp_o after reset", 32'(dat_hresp), 32'h0);
    check_value("tohost_done_o after reset", 32'(tohost_done), 32'h0);
    check_value("uart_valid_o after reset", 32'(uart_valid), 32'h0);

    // Back-to-back fills of the random windows and the table
    fill_words(32'h8000_0200, 64);
    fill_words(32'h8000_0300, 64);
    fill_words(32'h8000_1100, 16);
    pipe_cycle(1'b0, '0, 1'b0, 1'b0, HSIZE_WORD, '0, '0);
    pma_cfg[3] = '{MAIN, 1'b1, 1'b0, 1'b0, TOR};

    for (int i = 0; i < NV; i++) begin
      run_vector(VECTORS[i]);
      if (VECTORS[i].write && !VECTORS[i].err
          && VECTORS[i].addr[PLEN-1:2] == TOHOST[PLEN-1:2]) begin
        wait_tohost(VECTORS[i].data);
      end
    end

    random_traffic();
    repeat (4) @(negedge HCLK);

    // One strobe per UART write, in order
    check_value("uart pulse count", 32'(uart_seen.size()), 32'(uart_expect.size()));
    for (int i = 0; i < uart_expect.size() && i < uart_seen.size(); i++) begin
      check_value("uart_data_o", 32'(uart_seen[i]), 32'(uart_expect[i]));
    end
    check_value("tohost_done_o held", 32'(tohost_done), 32'h1);

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: verilog/ahb_addr_stage.sv
/*
 * Per-port AHB-Lite address-phase stage: registers the transfer, checks
 * PMA permissions, runs the two-cycle ERROR response, muxes read data
 */
module ahb_addr_stage import ahb_sys_pkg::*; #(
  parameter int PMA_CNT  = 4,
  parameter bit IS_FETCH = 1'b0
) (
  input  logic                              HCLK,
  input  logic                              rst_i,
  input  htrans_t                           htrans_i,
  input  logic     [PLEN-1:0]               haddr_i,
  input  logic                              hwrite_i,
  input  hsize_t                            hsize_i,
  input  pma_cfg_t [PMA_CNT-1:0]            pma_cfg_i,
  input  logic     [PMA_CNT-1:0][PLEN-1:0]  pma_adr_i,
  input  logic     [XLEN-1:0]               rdata_i,
  output ahb_req_t                          req_o,
  output logic     [XLEN-1:0]               hrdata_o,
  output logic                              hready_o,
  output logic                              hresp_o
);

  logic     pma_hit;
  pma_cfg_t pma_cfg;
  logic     take;
  logic     is_write;
  logic     fault;
  ahb_req_t req_q;
  // ERROR response, first and second cycle
  logic     err1_q;
  logic     err2_q;

  ahb_pma_check #(
    .PMA_CNT (PMA_CNT)
  ) u_pma_check (
    .addr_i    (haddr_i),
    .pma_cfg_i (pma_cfg_i),
    .pma_adr_i (pma_adr_i),
    .hit_o     (pma_hit),
    .cfg_o     (pma_cfg)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Address phase
  ////////////////////////////////////////////////////////////////////////////

  // Bursts are treated as singles, so SEQ is taken like NONSEQ
  assign take     = hready_o && (htrans_i == NONSEQ || htrans_i == SEQ);
  // Fetch port is read-only
  assign is_write = IS_FETCH ? 1'b0 : hwrite_i;

  // Permission check by access kind
  always_comb begin
    fault = !pma_hit || (pma_cfg.mem_type == EMPTY);
    if (IS_FETCH) begin
      fault = fault || !pma_cfg.x;
    end else if (is_write) begin
      fault = fault || !pma_cfg.w;
    end else begin
      fault = fault || !pma_cfg.r;
    end
  end

  always_ff @(posedge HCLK) begin
    if (rst_i) begin
      req_q.valid <= 1'b0;
      err1_q      <= 1'b0;
      err2_q      <= 1'b0;
    end else begin
      // Faulted transfer never reaches the handlers
      req_q.valid <= take && !fault;
      err1_q      <= take && fault;
      err2_q      <= err1_q;
      if (take && !fault) begin
        req_q.addr  <= haddr_i;
        req_q.write <= is_write;
        req_q.size  <= hsize_i;
        req_q.is_io <= (pma_cfg.mem_type == IO);
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Data phase response
  ////////////////////////////////////////////////////////////////////////////

  assign req_o    = req_q;
  // IO reads return zero
  assign hrdata_o = (req_q.valid && !req_q.is_io) ? rdata_i : '0;
  // Stall only in the first ERROR cycle
  assign hready_o = !err1_q;
  assign hresp_o  = err1_q || err2_q;

endmodule

// File: verilog/ahb_dp_ram.sv
/*
 * Dual-port word RAM: combinational reads for both ports from the
 * registered request, byte-lane writes from the data port
 */
module ahb_dp_ram import ahb_sys_pkg::*; #(
  parameter int MEM_WORDS = 2048
) (
  input  logic            HCLK,
  input  ahb_req_t        ins_req_i,
  input  ahb_req_t        dat_req_i,
  input  logic [XLEN-1:0] dat_wdata_i,
  output logic [XLEN-1:0] ins_rdata_o,
  output logic [XLEN-1:0] dat_rdata_o
);

  ////////////////////////////////////////////////////////////////////////////
  // Storage and indexing
  ////////////////////////////////////////////////////////////////////////////

  // Power-of-two depth, address wraps
  localparam int AW = $clog2(MEM_WORDS);

  logic [XLEN-1:0]   mem [MEM_WORDS];

  logic [AW-1:0]     ins_idx;
  logic [AW-1:0]     dat_idx;
  logic              dat_act;
  logic              dat_we;
  logic [XLEN/8-1:0] dat_be;

  // Word index above the byte offset
  assign ins_idx = ins_req_i.addr[AW+1:2];
  assign dat_idx = dat_req_i.addr[AW+1:2];

  // RAM only serves non-IO data phases
  assign dat_act = dat_req_i.valid && !dat_req_i.is_io;
  assign dat_we  = dat_act && dat_req_i.write;

  assign dat_be  = lane_mask(dat_req_i.size, dat_req_i.addr[1:0]);

  ////////////////////////////////////////////////////////////////////////////
  // Read ports
  ////////////////////////////////////////////////////////////////////////////

  // Read during the data phase
  // Idle and IO cycles are zeroed in the address stage
  // A same-cycle fetch of a word being written sees the old value
  assign ins_rdata_o = mem[ins_idx];
  assign dat_rdata_o = mem[dat_idx];

  ////////////////////////////////////////////////////////////////////////////
  // Write port
  ////////////////////////////////////////////////////////////////////////////

  // HWDATA is lane-aligned, so each byte lands in place
  always_ff @(posedge HCLK) begin
    if (dat_we) begin
      for (int b = 0; b < XLEN / 8; b++) begin
        if (dat_be[b]) begin
          mem[dat_idx][b*8 +: 8] <= dat_wdata_i[b*8 +: 8];
        end
      end
    end
  end

endmodule

// File: verilog/ahb_mem_top.sv
/*
 * Memory subsystem top: instruction and data address stages, shared
 * dual-port RAM and MMIO catcher
 */
module ahb_mem_top import ahb_sys_pkg::*; #(
  parameter int              PMA_CNT   = 4,
  parameter int              MEM_WORDS = 2048,
  parameter logic [PLEN-1:0] TOHOST    = 32'h8000_1000,
  parameter logic [PLEN-1:0] UART_TX   = 32'h8000_1080
) (
  input  logic                              HCLK,
  input  logic                              rst_i,
  // Run-time region table
  input  pma_cfg_t [PMA_CNT-1:0]            pma_cfg_i,
  input  logic     [PMA_CNT-1:0][PLEN-1:0]  pma_adr_i,
  // Instruction port
  input  htrans_t                           ins_htrans_i,
  input  logic     [PLEN-1:0]               ins_haddr_i,
  input  logic                              ins_hwrite_i,
  input  hsize_t                            ins_hsize_i,
  output logic     [XLEN-1:0]               ins_hrdata_o,
  output logic                              ins_hready_o,
  output logic                              ins_hresp_o,
  // Data port
  input  htrans_t                           dat_htrans_i,
  input  logic     [PLEN-1:0]               dat_haddr_i,
  input  logic                              dat_hwrite_i,
  input  hsize_t                            dat_hsize_i,
  input  logic     [XLEN-1:0]               dat_hwdata_i,
  output logic     [XLEN-1:0]               dat_hrdata_o,
  output logic                              dat_hready_o,
  output logic                              dat_hresp_o,
  // Test exit and console
  output logic                              tohost_done_o,
  output logic     [XLEN-1:0]               tohost_code_o,
  output logic                              uart_valid_o,
  output logic     [7:0]                    uart_data_o
);

  ahb_req_t        ins_req;
  ahb_req_t        dat_req;
  logic [XLEN-1:0] ins_rdata;
  logic [XLEN-1:0] dat_rdata;

  ////////////////////////////////////////////////////////////////////////////
  // Address stages
  ////////////////////////////////////////////////////////////////////////////

  // Fetch port, write flag ignored inside
  ahb_addr_stage #(
    .PMA_CNT  (PMA_CNT),
    .IS_FETCH (1'b1)
  ) u_ins_stage (
    .HCLK      (HCLK),
    .rst_i     (rst_i),
    .htrans_i  (ins_htrans_i),
    .haddr_i   (ins_haddr_i),
    .hwrite_i  (ins_hwrite_i),
    .hsize_i   (ins_hsize_i),
    .pma_cfg_i (pma_cfg_i),
    .pma_adr_i (pma_adr_i),
    .rdata_i   (ins_rdata),
    .req_o     (ins_req),
    .hrdata_o  (ins_hrdata_o),
    .hready_o  (ins_hready_o),
    .hresp_o   (ins_hresp_o)
  );

  ahb_addr_stage #(
    .PMA_CNT  (PMA_CNT),
    .IS_FETCH (1'b0)
  ) u_dat_stage (
    .HCLK      (HCLK),
    .rst_i     (rst_i),
    .htrans_i  (dat_htrans_i),
    .haddr_i   (dat_haddr_i),
    .hwrite_i  (dat_hwrite_i),
    .hsize_i   (dat_hsize_i),
    .pma_cfg_i (pma_cfg_i),
    .pma_adr_i (pma_adr_i),
    .rdata_i   (dat_rdata),
    .req_o     (dat_req),
    .hrdata_o  (dat_hrdata_o),
    .hready_o  (dat_hready_o),
    .hresp_o   (dat_hresp_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Data-phase handlers
  ////////////////////////////////////////////////////////////////////////////

  ahb_dp_ram #(
    .MEM_WORDS (MEM_WORDS)
  ) u_ram (
    .HCLK        (HCLK),
    .ins_req_i   (ins_req),
    .dat_req_i   (dat_req),
    .dat_wdata_i (dat_hwdata_i),
    .ins_rdata_o (ins_rdata),
    .dat_rdata_o (dat_rdata)
  );

  // Sees only data-port IO requests
  ahb_mmio_catch #(
    .TOHOST  (TOHOST),
    .UART_TX (UART_TX)
  ) u_mmio_catch (
    .HCLK          (HCLK),
    .rst_i         (rst_i),
    .req_i         (dat_req),
    .wdata_i       (dat_hwdata_i),
    .tohost_done_o (tohost_done_o),
    .tohost_code_o (tohost_code_o),
    .uart_valid_o  (uart_valid_o),
    .uart_data_o   (uart_data_o)
  );

endmodule

// File: verilog/ahb_mmio_catch.sv
/*
 * MMIO catcher on the data port: latches the TOHOST exit code and
 * strobes bytes written to UART_TX
 */
module ahb_mmio_catch import ahb_sys_pkg::*; #(
  parameter logic [PLEN-1:0] TOHOST  = 32'h8000_1000,
  parameter logic [PLEN-1:0] UART_TX = 32'h8000_1080
) (
  input  logic            HCLK,
  input  logic            rst_i,
  input  ahb_req_t        req_i,
  input  logic [XLEN-1:0] wdata_i,
  output logic            tohost_done_o,
  output logic [XLEN-1:0] tohost_code_o,
  output logic            uart_valid_o,
  output logic [7:0]      uart_data_o
);

  logic io_wr;
  logic tohost_hit;
  logic uart_hit;

  ////////////////////////////////////////////////////////////////////////////
  // Register decode
  ////////////////////////////////////////////////////////////////////////////

  // Only IO writes count, reads fall through as zero
  assign io_wr      = req_i.valid && req_i.is_io && req_i.write;
  // Word compare, size and byte offset ignored
  assign tohost_hit = io_wr && (req_i.addr[PLEN-1:2] == TOHOST[PLEN-1:2]);
  assign uart_hit   = io_wr && (req_i.addr[PLEN-1:2] == UART_TX[PLEN-1:2]);

  ////////////////////////////////////////////////////////////////////////////
  // Control flags
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge HCLK) begin
    if (rst_i) begin
      tohost_done_o <= 1'b0;
      uart_valid_o  <= 1'b0;
    end else begin
      // Done is sticky until reset
      if (tohost_hit) begin
        tohost_done_o <= 1'b1;
      end
      // One-cycle strobe per UART write
      uart_valid_o <= uart_hit;
    end
  end

  // Captured payloads
  always_ff @(posedge HCLK) begin
    if (tohost_hit) begin
      tohost_code_o <= wdata_i;
    end
    if (uart_hit) begin
      uart_data_o <= wdata_i[7:0];
    end
  end

endmodule

// File: verilog/ahb_pma_check.sv
/*
 * PMA region matcher: evaluates all regions in parallel (TOR, NA4, NAPOT)
 * and returns the attributes of the lowest-numbered hit
 */
module ahb_pma_check import ahb_sys_pkg::*; #(
  parameter int PMA_CNT = 4
) (
  input  logic     [PLEN-1:0]               addr_i,
  input  pma_cfg_t [PMA_CNT-1:0]            pma_cfg_i,
  input  logic     [PMA_CNT-1:0][PLEN-1:0]  pma_adr_i,
  output logic                              hit_o,
  output pma_cfg_t                          cfg_o
);

  ////////////////////////////////////////////////////////////////////////////
  // Address alignment
  ////////////////////////////////////////////////////////////////////////////

  // Region addresses are byte address >> 2, same as pmpaddr
  logic [PLEN-1:0]    word_adr;
  logic [PMA_CNT-1:0] region_hit;

  assign word_adr = {2'b00, addr_i[PLEN-1:2]};

  ////////////////////////////////////////////////////////////////////////////
  // Per-region match
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin : region_match
    logic [PLEN-1:0] lo_bound;
    logic [PLEN-1:0] napot_mask;
    // First TOR entry starts at address zero
    lo_bound = '0;
    for (int i = 0; i < PMA_CNT; i++) begin
      // Trailing ones plus the next zero give the don't-care bits
      napot_mask = ~(pma_adr_i[i] ^ (pma_adr_i[i] + 1'b1));
      case (pma_cfg_i[i].match)
        TOR: begin
          region_hit[i] = (word_adr >= lo_bound) && (word_adr < pma_adr_i[i]);
        end
        NA4: begin
          region_hit[i] = (word_adr == pma_adr_i[i]);
        end
        NAPOT: begin
          region_hit[i] = ((word_adr & napot_mask) == (pma_adr_i[i] & napot_mask));
        end
        default: begin
          // OFF entry never matches
          region_hit[i] = 1'b0;
        end
      endcase
      // Next TOR entry uses this address as its base
      lo_bound = pma_adr_i[i];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Priority pick
  ////////////////////////////////////////////////////////////////////////////

  // Walk downwards so the lowest index overwrites last
  always_comb begin
    hit_o = 1'b0;
    cfg_o = '0;
    for (int i = PMA_CNT - 1; i >= 0; i--) begin
      if (region_hit[i]) begin
        hit_o = 1'b1;
        cfg_o = pma_cfg_i[i];
      end
    end
  end

endmodule

// File: verilog/ahb_sys_pkg.sv
/*
 * Shared definitions for the dual-port AHB-Lite memory subsystem:
 * bus widths, AHB encodings, PMA region types, stage request struct
 */
package ahb_sys_pkg;

  // Bus widths
  localparam int XLEN = 32;
  localparam int PLEN = 32;

  ////////////////////////////////////////////////////////////////////////////
  // AHB-Lite encodings
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } htrans_t;

  // Only sizes up to the bus width are legal
  typedef enum logic [2:0] {
    HSIZE_BYTE = 3'b000,
    HSIZE_HALF = 3'b001,
    HSIZE_WORD = 3'b010
  } hsize_t;

  ////////////////////////////////////////////////////////////////////////////
  // Physical memory attributes
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    EMPTY = 2'b00,
    MAIN  = 2'b01,
    IO    = 2'b10
  } mem_type_t;

  // Same meaning as the RISC-V PMP address-matching field
  typedef enum logic [1:0] {
    OFF   = 2'b00,
    TOR   = 2'b01,
    NA4   = 2'b10,
    NAPOT = 2'b11
  } pma_match_t;

  typedef struct packed {
    mem_type_t  mem_type;
    logic       r;
    logic       w;
    logic       x;
    pma_match_t match;
  } pma_cfg_t;

  // Data-phase descriptor from an address stage
  typedef struct packed {
    logic            valid;
    logic [PLEN-1:0] addr;
    logic            write;
    hsize_t          size;
    logic            is_io;
  } ahb_req_t;

  // Byte lanes touched by a transfer of the given size and offset
  function automatic logic [XLEN/8-1:0] lane_mask(hsize_t size, logic [1:0] offs);
    logic [XLEN/8-1:0] m;
    case (size)
      HSIZE_BYTE: m = 4'b0001 << offs;
      HSIZE_HALF: m = 4'b0011 << {offs[1], 1'b0};
      default:    m = '1;
    endcase
    return m;
  endfunction

endpackage
